//--- verilog/mem_pkg.sv
package mem_pkg;

    // 1 KiB data memory
    localparam int mem_depth  = 1024;
    localparam int addr_width = 10;

    // funct3 style width code, bit 2 means unsigned
    typedef logic [2:0] width_t;

    localparam width_t w_byte   = 3'b000;
    localparam width_t w_half   = 3'b001;
    localparam width_t w_word   = 3'b010;
    localparam width_t w_byte_u = 3'b100;
    localparam width_t w_half_u = 3'b101;

    // one bit per byte lane, bit 3 is offset 0
    typedef logic [3:0] frame_mask_t;

    localparam frame_mask_t mask_b0   = 4'b1000;
    localparam frame_mask_t mask_b1   = 4'b0100;
    localparam frame_mask_t mask_b2   = 4'b0010;
    localparam frame_mask_t mask_b3   = 4'b0001;
    localparam frame_mask_t mask_h0   = 4'b1100;
    localparam frame_mask_t mask_h2   = 4'b0011;
    localparam frame_mask_t mask_word = 4'b1111;

    // big-endian lanes: lanes[3] is the top byte at offset 0
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } word_lanes_t;

endpackage

//--- verilog/mem_if.sv
`timescale 1ns/1ps

// load/store unit to byte sequencer
interface lsu_seq_if;
    import mem_pkg::*;

    logic                  start;
    logic                  write;
    frame_mask_t           mask;
    logic [addr_width-1:0] word_addr;
    word_lanes_t           wdata;
    word_lanes_t           rdata;
    logic                  done;

    modport lsu (output start, write, mask, word_addr, wdata, input rdata, done);
    modport seq (input start, write, mask, word_addr, wdata, output rdata, done);
endinterface

// byte sequencer to RAM
interface ram_if;
    import mem_pkg::*;

    logic                  en;
    logic                  we;
    logic [addr_width-1:0] addr;
    logic [7:0]            wbyte;
    logic [7:0]            rbyte;

    modport ctrl (output en, we, addr, wbyte, input rbyte);
    modport ram (input en, we, addr, wbyte, output rbyte);
endinterface

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           req,
    input  logic                           write,
    input  mem_pkg::width_t                width,
    input  logic [mem_pkg::addr_width-1:0] addr,
    input  logic [31:0]                    wdata,
    output logic [31:0]                    rdata,
    output logic                           done,
    output logic                           misaligned,
    output logic                           busy,
    lsu_seq_if.lsu                         seq
);
    import mem_pkg::*;

    logic                  req_q;
    logic                  accept;
    logic                  write_q;
    width_t                width_q;
    logic [addr_width-1:0] addr_q;
    logic [31:0]           wdata_q;
    logic [1:0]            off;

    logic        aligned;
    frame_mask_t mask_sel;
    word_lanes_t lanes_sel;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ext_val;

    assign accept = req && !busy && !req_q;
    assign off    = addr_q[1:0];

    // alignment, frame mask and store lane placement
    always_comb begin
        aligned        = 1'b0;
        mask_sel       = mask_word;
        lanes_sel.word = wdata_q;
        case (width_q[1:0])
            w_byte[1:0]: begin
                aligned = 1'b1;
                case (off)
                    2'd0:    mask_sel = mask_b0;
                    2'd1:    mask_sel = mask_b1;
                    2'd2:    mask_sel = mask_b2;
                    default: mask_sel = mask_b3;
                endcase
                lanes_sel.word       = '0;
                lanes_sel.lanes[~off] = wdata_q[7:0];
            end
            w_half[1:0]: begin
                aligned = !off[0];
                if (off[1]) begin
                    mask_sel       = mask_h2;
                    lanes_sel.word = {16'b0, wdata_q[15:0]};
                end else begin
                    mask_sel       = mask_h0;
                    lanes_sel.word = {wdata_q[15:0], 16'b0};
                end
            end
            w_word[1:0]: begin
                aligned = (off == 2'd0);
            end
            // doubleword is not supported here
            default: aligned = 1'b0;
        endcase
    end

    // pick addressed lanes out of the returned word
    always_comb begin
        ld_byte = seq.rdata.lanes[~off];
        ld_half = off[1] ? seq.rdata.word[15:0] : seq.rdata.word[31:16];
        case (width_q)
            w_byte:   ext_val = {{24{ld_byte[7]}}, ld_byte};
            w_byte_u: ext_val = {24'b0, ld_byte};
            w_half:   ext_val = {{16{ld_half[15]}}, ld_half};
            w_half_u: ext_val = {16'b0, ld_half};
            default:  ext_val = seq.rdata.word;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            req_q      <= 1'b0;
            seq.start  <= 1'b0;
            misaligned <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            req_q      <= accept;
            seq.start  <= req_q && aligned;
            misaligned <= req_q && !aligned;
            done       <= seq.done;
            if (req_q && aligned) begin
                busy <= 1'b1;
            end else if (seq.done) begin
                busy <= 1'b0;
            end
        end
    end

    // request payload, held until the next accepted request
    always_ff @(posedge CLK) begin
        if (accept) begin
            write_q <= write;
            width_q <= width;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (req_q && aligned) begin
            seq.write     <= write_q;
            seq.mask      <= mask_sel;
            seq.word_addr <= {addr_q[addr_width-1:2], 2'b00};
            seq.wdata     <= lanes_sel;
        end
        if (seq.done) begin
            rdata <= ext_val;
        end
    end

endmodule

//--- verilog/byte_sequencer.sv
`timescale 1ns/1ps

module byte_sequencer (
    input  logic    CLK,
    input  logic    rst_n,
    lsu_seq_if.seq  seq,
    ram_if.ctrl     ram
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_walk,
        st_finish
    } state_t;

    state_t      state;
    frame_mask_t rem;
    frame_mask_t next_rem;
    logic [1:0]  cur_off;
    logic        pend_rd;
    logic [1:0]  pend_lane;
    word_lanes_t rdata_q;

    // smallest offset whose mask bit is set
    function automatic logic [1:0] first_off(frame_mask_t m);
        logic [1:0] off;
        off = 2'd0;
        for (int o = 3; o >= 0; o--) begin
            if (m[3-o]) begin
                off = o[1:0];
            end
        end
        return off;
    endfunction

    // drop the offset handled in this step
    assign next_rem = rem & ~(frame_mask_t'(4'b1000) >> cur_off);

    // one byte per walk cycle, lane index is 3 - offset
    assign ram.en    = (state == st_walk);
    assign ram.we    = (state == st_walk) && seq.write;
    assign ram.addr  = {seq.word_addr[addr_width-1:2], cur_off};
    assign ram.wbyte = seq.wdata.lanes[~cur_off];

    assign seq.done = (state == st_finish);

    // last read byte is merged in so rdata is complete with done
    always_comb begin
        seq.rdata = rdata_q;
        if (pend_rd) begin
            seq.rdata.lanes[pend_lane] = ram.rbyte;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state   <= st_idle;
            rem     <= '0;
            cur_off <= 2'd0;
            pend_rd <= 1'b0;
        end else begin
            pend_rd <= (state == st_walk) && !seq.write;
            case (state)
                st_idle: begin
                    if (seq.start && seq.mask != '0) begin
                        rem     <= seq.mask;
                        cur_off <= first_off(seq.mask);
                        state   <= st_walk;
                    end
                end
                st_walk: begin
                    rem <= next_rem;
                    if (next_rem == '0) begin
                        state <= st_finish;
                    end else begin
                        cur_off <= first_off(next_rem);
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read data path
    always_ff @(posedge CLK) begin
        pend_lane <= ~cur_off;
        if (pend_rd) begin
            rdata_q.lanes[pend_lane] <= ram.rbyte;
        end
    end

endmodule

//--- verilog/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input  logic CLK,
    ram_if.ram   ram
);
    import mem_pkg::*;

    logic [7:0] mem [0:mem_depth-1];

    // read returns the old byte on a write cycle
    always_ff @(posedge CLK) begin
        if (ram.en) begin
            if (ram.we) begin
                mem[ram.addr] <= ram.wbyte;
            end
            ram.rbyte <= mem[ram.addr];
        end
    end

endmodule

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           req,
    input  logic                           write,
    input  mem_pkg::width_t                width,
    input  logic [mem_pkg::addr_width-1:0] addr,
    input  logic [31:0]                    wdata,
    output logic [31:0]                    rdata,
    output logic                           done,
    output logic                           misaligned,
    output logic                           busy
);

    lsu_seq_if seq_bus ();
    ram_if     ram_bus ();

    // request decode and load extension
    load_store_unit u_lsu (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .req        (req),
        .write      (write),
        .width      (width),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .done       (done),
        .misaligned (misaligned),
        .busy       (busy),
        .seq        (seq_bus.lsu)
    );

    byte_sequencer u_seq (
        .CLK   (CLK),
        .rst_n (rst_n),
        .seq   (seq_bus.seq),
        .ram   (ram_bus.ctrl)
    );

    byte_ram u_ram (
        .CLK (CLK),
        .ram (ram_bus.ram)
    );

endmodule

//--- test/mem_subsystem_chk.sv
`timescale 1ns/1ps

module mem_subsystem_chk (
    input logic CLK,
    input logic rst_n,
    input logic req,
    input logic busy,
    input logic done,
    input logic misaligned
);

    logic busy_d;
    logic busy_rise;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy_d <= 1'b0;
        end else begin
            busy_d <= busy;
        end
    end

    assign busy_rise = busy && !busy_d;

    // a request ends in done or in misaligned, not both
    done_or_misaligned: assert property (@(posedge CLK) disable iff (!rst_n)
        !(done && misaligned))
        else $error("done and misaligned are high in the same cycle");

    no_req_while_busy: assert property (@(posedge CLK) disable iff (!rst_n)
        !(req && busy))
        else $error("req is high while busy");

    // n+2 cycles after busy rises, for 1, 2 or 4 bytes
    done_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        done |-> ($past(busy_rise, 3) || $past(busy_rise, 4) || $past(busy_rise, 6)))
        else $error("done is not 3, 4 or 6 cycles after busy rose");

endmodule

bind mem_subsystem mem_subsystem_chk chk (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .req        (req),
    .busy       (busy),
    .done       (done),
    .misaligned (misaligned)
);

//--- test/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;
    import mem_pkg::*;

    logic                  CLK;
    logic                  rst_n;
    logic                  req;
    logic                  write;
    width_t                width;
    logic [addr_width-1:0] addr;
    logic [31:0]           wdata;
    logic [31:0]           rdata;
    logic                  done;
    logic                  misaligned;
    logic                  busy;

    // byte model of the RAM with offset 0 in the top byte of a word
    logic [7:0]  model [0:mem_depth-1];
    int          cycles;
    logic        busy_gap;
    logic [31:0] end_flags;

    mem_subsystem DUT (.*);

    always #2 CLK = ~CLK;

    task automatic raise_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else raise_failure(
            $sformatf("[ERROR] %0t: %s is %08h, expected %08h", $time, what, got, exp));
    endtask

    // req for one cycle and a wait for done or misaligned
    task automatic access(input logic wr, input width_t wd, input logic [addr_width-1:0] a,
                          input logic [31:0] d);
        @(negedge CLK);
        req   = 1'b1;
        write = wr;
        width = wd;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        req      = 1'b0;
        cycles   = 0;
        busy_gap = 1'b0;
        while (!(done || misaligned) && cycles < 40) begin
            @(negedge CLK);
            cycles++;
            busy_gap = busy_gap || (!(done || misaligned) && !busy);
        end
        if (!(done || misaligned)) begin
            raise_failure("timeout: no done or misaligned within 40 cycles of a request");
        end
        end_flags = {29'b0, done, misaligned, busy};
    endtask

    // big-endian read of 1, 2 or 4 model bytes and the extension
    function automatic logic [31:0] expected_load(input width_t wd,
                                                  input logic [addr_width-1:0] a);
        logic [31:0] v;
        int          n;
        n = 1 << wd[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[23:0], model[a + 10'(i)]};
        end
        if (!wd[2] && n < 4 && v[8*n-1]) begin
            v = v | (32'hffff_ffff << (8 * n));
        end
        return v;
    endfunction

    // aligned access with loads compared against the model
    task automatic checked_access(input logic wr, input width_t wd,
                                  input logic [addr_width-1:0] a, input logic [31:0] d);
        int n;
        n = 1 << wd[1:0];
        access(wr, wd, a, d);
        check_value($sformatf("done/misaligned/busy at %03h", a), end_flags, 32'd4);
        if (wr) begin
            for (int i = 0; i < n; i++) begin
                model[a + 10'(i)] = d[8*(n-1-i) +: 8];
            end
        end else begin
            check_value($sformatf("load %0d at %03h", wd, a), rdata, expected_load(wd, a));
        end
    endtask

    task automatic reset_defaults();
        check_value("done/misaligned/busy after reset", {29'b0, done, misaligned, busy}, 32'd0);
        repeat (10) begin
            @(negedge CLK);
            check_value("done while idle", {31'b0, done}, 32'd0);
        end
    endtask

    task automatic word_roundtrip();
        logic [31:0]           r;
        logic [addr_width-1:0] a [8];
        for (int i = 0; i < 8; i++) begin
            r    = $urandom();
            a[i] = {r[9:2], 2'b00};
            checked_access(1'b1, w_word, a[i], $urandom());
        end
        for (int i = 0; i < 8; i++) begin
            checked_access(1'b0, w_word, a[i], 32'h0);
        end
    endtask

    task automatic lane_order();
        for (int i = 0; i < 4; i++) begin
            checked_access(1'b1, w_byte, 10'h100 + 10'(i), 32'(i + 1) * 32'h11);
        end
        access(1'b0, w_word, 10'h100, 32'h0);
        check_value("word after byte stores", rdata, 32'h1122_3344);
        checked_access(1'b1, w_half, 10'h104, 32'h0000_a1b2);
        checked_access(1'b1, w_half, 10'h106, 32'h0000_c3d4);
        access(1'b0, w_word, 10'h104, 32'h0);
        check_value("word after half stores", rdata, 32'ha1b2_c3d4);
    endtask

    task automatic load_extension();
        checked_access(1'b1, w_word, 10'h200, 32'hf081_c37f);
        checked_access(1'b1, w_word, 10'h204, $urandom() | 32'h8080_8080);
        for (int k = 0; k < 8; k++) begin
            checked_access(1'b0, w_byte, 10'h200 + 10'(k), 32'h0);
            checked_access(1'b0, w_byte_u, 10'h200 + 10'(k), 32'h0);
            if (k % 2 == 0) begin
                checked_access(1'b0, w_half, 10'h200 + 10'(k), 32'h0);
                checked_access(1'b0, w_half_u, 10'h200 + 10'(k), 32'h0);
            end
        end
    endtask

    task automatic misaligned_access();
        width_t                wd [5];
        logic [addr_width-1:0] a [5];
        wd = '{w_half, w_half_u, w_word, w_word, w_word};
        a  = '{10'h301, 10'h303, 10'h301, 10'h302, 10'h303};
        checked_access(1'b1, w_word, 10'h300, $urandom());
        for (int i = 0; i < 5; i++) begin
            access(i % 2 == 0, wd[i], a[i], 32'hffff_ffff);
            check_value($sformatf("done/misaligned/busy at %03h", a[i]), end_flags, 32'd2);
            repeat (4) begin
                @(negedge CLK);
                check_value("done after misaligned", {31'b0, done}, 32'd0);
            end
        end
        // memory must still hold the first store
        checked_access(1'b0, w_word, 10'h300, 32'h0);
    endtask

    task automatic access_latency();
        width_t wd [3];
        int     n [3];
        wd = '{w_byte, w_half, w_word};
        n  = '{4, 5, 7};
        for (int i = 0; i < 6; i++) begin
            checked_access(i % 2 == 0, wd[i/2], 10'h3f0, $urandom());
            check_value("cycles from req to done", 32'(cycles), 32'(n[i/2]));
            check_value("busy low inside an access", {31'b0, busy_gap}, 32'd0);
        end
    endtask

    initial begin
        CLK   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        write = 1'b0;
        width = w_word;
        addr  = '0;
        wdata = '0;
        void'($urandom(32'hdf67));
        repeat (8) @(negedge CLK);
        rst_n = 1'b1;
        reset_defaults();
        word_roundtrip();
        lane_order();
        load_extension();
        misaligned_access();
        access_latency();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- filelist.f
verilog/mem_pkg.sv
verilog/mem_if.sv
verilog/load_store_unit.sv
verilog/byte_sequencer.sv
verilog/byte_ram.sv
verilog/mem_subsystem.sv
test/mem_subsystem_chk.sv
test/mem_subsystem_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_subsystem_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
